/* include/digit_overlay_params.svh */
`ifndef DIGIT_OVERLAY_PARAMS_SVH
`define DIGIT_OVERLAY_PARAMS_SVH

// --------------------
// binary image geometry
`define DO_IMG_N            28      // cells per side
`define DO_DECIM_SHIFT      3       // keep every 8th pixel and line
`define DO_BIN_THRESH       30      // dark when r5+g6+b5 below this

// --------------------
// class indicator
`define DO_CLASS_N          10      // one cell per digit

// --------------------
// display windows, origins in cells
`define DO_BIN_CELL_SHIFT   4       // 16x16 display pixels per image cell
`define DO_BIN_X0           50
`define DO_BIN_Y0           1
`define DO_CLASS_CELL_SHIFT 5       // 32x32 pixels per class cell
`define DO_CLASS_X0         1
`define DO_CLASS_Y0         18

// --------------------
// counter widths
`define DO_CAM_X_W          11
`define DO_CAM_Y_W          10
`define DO_DISP_X_W         12
`define DO_DISP_Y_W         11

`endif

/* logic/digit_overlay_pkg.sv */
`include "digit_overlay_params.svh"

package digit_overlay_pkg;

    // --------------------
    // display layer per pixel
    typedef enum logic [1:0] {
        LAYER_BG    = 2'd0,          // gradient background
        LAYER_BIN   = 2'd1,          // 28x28 binary window
        LAYER_CLASS = 2'd2           // ten-cell class bar
    } layer_e;

    // --------------------
    // pixel formats
    typedef logic [15:0] rgb565_t;   // r[15:11] g[10:5] b[4:0]
    typedef logic [23:0] rgb888_t;   // r[23:16] g[15:8] b[7:0]

    // --------------------
    // binary image
    typedef logic [`DO_IMG_N-1:0] row_bits_t;  // bit n is column n
    typedef logic [4:0]           cell_idx_t;  // row or column, 0..27

endpackage

/* logic/bin_wr_if.sv */
`timescale 1ns/1ps

// sampler to row stores, no handshake
interface bin_wr_if
    import digit_overlay_pkg::*;
();

    logic      wr;       // one-cycle write strobe
    cell_idx_t row;      // target row of live image
    cell_idx_t col;      // target column
    logic      bit_val;  // thresholded pixel
    logic      latch;    // live to shown, once per frame

    modport sampler (
        output wr,
        output row,
        output col,
        output bit_val,
        output latch
    );

    modport store (
        input  wr,
        input  row,
        input  col,
        input  bit_val,
        input  latch
    );

endinterface

/* logic/cam_sampler.sv */
`timescale 1ns/1ps
`include "digit_overlay_params.svh"

module cam_sampler
    import digit_overlay_pkg::*;
(
    input  logic      video_clk,
    input  logic      rst_n,
    input  logic      cam_vsync,   // high during vertical blank
    input  logic      cam_href,    // high while pixels valid
    input  rgb565_t   cam_data,
    bin_wr_if.sampler wr_bus
);

    // --------------------
    // camera position
    logic [`DO_CAM_X_W-1:0] cam_x;     // pixel index in line
    logic [`DO_CAM_Y_W-1:0] cam_y;     // line index in frame
    logic                   href_d;    // for href fall
    logic                   vsync_d;   // for vsync rise

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            cam_x   <= '0;
            cam_y   <= '0;
            href_d  <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            href_d  <= cam_href;
            vsync_d <= cam_vsync;
            if (!cam_href) begin
                cam_x <= '0;                      // idle between lines
            end else begin
                cam_x <= cam_x + 1'b1;
            end
            if (cam_vsync) begin
                cam_y <= '0;                      // held through blank
            end else if (href_d && !cam_href) begin
                cam_y <= cam_y + 1'b1;            // one per finished line
            end
        end
    end

    // --------------------
    // decimation and threshold
    logic [`DO_CAM_X_W-`DO_DECIM_SHIFT-1:0] x_cell;
    logic [`DO_CAM_Y_W-`DO_DECIM_SHIFT-1:0] y_cell;
    logic [7:0]                             ch_sum;   // r5+g6+b5, max 125
    logic                                   take;     // this pixel is a sample
    logic                                   vs_rise;

    assign x_cell = cam_x[`DO_CAM_X_W-1:`DO_DECIM_SHIFT];
    assign y_cell = cam_y[`DO_CAM_Y_W-1:`DO_DECIM_SHIFT];

    assign ch_sum = 8'(cam_data[15:11]) + 8'(cam_data[10:5]) + 8'(cam_data[4:0]);

    assign take = cam_href
               && (cam_x[`DO_DECIM_SHIFT-1:0] == '0)
               && (cam_y[`DO_DECIM_SHIFT-1:0] == '0)
               && (x_cell < `DO_IMG_N)               // inside 224x224
               && (y_cell < `DO_IMG_N);

    assign vs_rise = cam_vsync && !vsync_d;

    // strobes, one cycle after the pixel
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bus.wr    <= 1'b0;
            wr_bus.latch <= 1'b0;
        end else begin
            wr_bus.wr    <= take;
            wr_bus.latch <= vs_rise;                 // frame boundary
        end
    end

    // write payload, only looked at with wr
    always_ff @(posedge video_clk) begin
        if (take) begin
            wr_bus.row     <= cell_idx_t'(y_cell);
            wr_bus.col     <= cell_idx_t'(x_cell);
            wr_bus.bit_val <= (ch_sum < `DO_BIN_THRESH);  // dark pixel -> 1
        end
    end

endmodule

/* logic/bin_row.sv */
`timescale 1ns/1ps

module bin_row
    import digit_overlay_pkg::*;
#(
    parameter cell_idx_t ROW_ID = '0     // image row this store holds
)(
    input  logic      video_clk,
    input  logic      rst_n,
    bin_wr_if.store   wr_bus,
    output row_bits_t shown              // stable copy for the display
);

    // --------------------
    // live row, filled by the sampler
    row_bits_t live;
    logic      hit;                      // write aimed at this row

    assign hit = wr_bus.wr && (wr_bus.row == ROW_ID);

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            live  <= '0;
            shown <= '0;
        end else begin
            if (hit) begin
                live[wr_bus.col] <= wr_bus.bit_val;   // single column update
            end
            // whole-frame swap, display never sees a partial image
            if (wr_bus.latch) begin
                shown <= live;
            end
        end
    end

endmodule

/* logic/overlay_mixer.sv */
`timescale 1ns/1ps
`include "digit_overlay_params.svh"

module overlay_mixer
    import digit_overlay_pkg::*;
(
    input  logic                  video_clk,
    input  logic                  rst_n,
    input  logic                  disp_vs,    // high in vertical blank
    input  logic                  disp_de,    // active video
    input  row_bits_t             rows [`DO_IMG_N],
    input  logic [`DO_CLASS_N-1:0] class_onehot,
    output logic                  out_de,
    output rgb888_t               rgb
);

    // --------------------
    // raster position
    logic [`DO_DISP_X_W-1:0] disp_x;      // pixel in line, valid with disp_de
    logic [`DO_DISP_Y_W-1:0] disp_y;      // line in frame
    logic                    de_d;        // de one cycle late

    // cell coordinates of both windows
    logic [`DO_DISP_X_W-`DO_BIN_CELL_SHIFT-1:0]   bin_xc;
    logic [`DO_DISP_Y_W-`DO_BIN_CELL_SHIFT-1:0]   bin_yc;
    logic [`DO_DISP_X_W-`DO_CLASS_CELL_SHIFT-1:0] cls_xc;
    logic [`DO_DISP_Y_W-`DO_CLASS_CELL_SHIFT-1:0] cls_yc;

    logic      in_bin;
    logic      in_class;
    cell_idx_t bin_r;                     // image row under the beam
    cell_idx_t bin_c;
    logic [3:0] cls_idx;                  // class cell under the beam

    layer_e    layer_d;
    layer_e    layer_q;
    logic      bit_d;
    logic      bit_q;
    logic [7:0] grad_r;                   // gradient bytes, stage 1
    logic [7:0] grad_g;

    assign bin_xc = disp_x[`DO_DISP_X_W-1:`DO_BIN_CELL_SHIFT];
    assign bin_yc = disp_y[`DO_DISP_Y_W-1:`DO_BIN_CELL_SHIFT];
    assign cls_xc = disp_x[`DO_DISP_X_W-1:`DO_CLASS_CELL_SHIFT];
    assign cls_yc = disp_y[`DO_DISP_Y_W-1:`DO_CLASS_CELL_SHIFT];

    assign in_bin = (bin_xc >= `DO_BIN_X0) && (bin_xc < `DO_BIN_X0 + `DO_IMG_N)
                 && (bin_yc >= `DO_BIN_Y0) && (bin_yc < `DO_BIN_Y0 + `DO_IMG_N);

    assign in_class = (cls_xc >= `DO_CLASS_X0) && (cls_xc < `DO_CLASS_X0 + `DO_CLASS_N)
                   && (cls_yc == `DO_CLASS_Y0);          // single row of cells

    assign bin_r   = cell_idx_t'(bin_yc - `DO_BIN_Y0);
    assign bin_c   = cell_idx_t'(bin_xc - `DO_BIN_X0);
    assign cls_idx = 4'(cls_xc - `DO_CLASS_X0);

    // --------------------
    // layer pick, binary window on top
    always_comb begin
        layer_d = LAYER_BG;
        bit_d   = 1'b0;
        if (in_bin) begin
            layer_d = LAYER_BIN;
            bit_d   = rows[bin_r][bin_c];
        end else if (in_class) begin
            layer_d = LAYER_CLASS;
            bit_d   = class_onehot[cls_idx];
        end
    end

    // counters and stage 1
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            disp_x  <= '0;
            disp_y  <= '0;
            de_d    <= 1'b0;
            layer_q <= LAYER_BG;
            bit_q   <= 1'b0;
            grad_r  <= '0;
            grad_g  <= '0;
        end else begin
            de_d <= disp_de;
            if (!disp_de) begin
                disp_x <= '0;                         // back to 0 in blank
            end else begin
                disp_x <= disp_x + 1'b1;
            end
            if (disp_vs) begin
                disp_y <= '0;
            end else if (de_d && !disp_de) begin
                disp_y <= disp_y + 1'b1;              // de fall ends a line
            end
            layer_q <= layer_d;
            bit_q   <= bit_d;
            grad_r  <= disp_x[7:0];
            grad_g  <= disp_y[7:0];
        end
    end

    // --------------------
    // stage 2, colour out
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_de <= 1'b0;
            rgb    <= '0;
        end else begin
            out_de <= de_d;                           // 2 cycles after disp_de
            case (layer_q)
                LAYER_BIN,
                LAYER_CLASS: rgb <= {24{bit_q}};      // black or white
                default:     rgb <= {grad_r, grad_g, 8'hff};
            endcase
        end
    end

endmodule

/* logic/digit_overlay_top.sv */
`timescale 1ns/1ps
`include "digit_overlay_params.svh"

module digit_overlay_top
    import digit_overlay_pkg::*;
(
    input  logic                   video_clk,
    input  logic                   rst_n,
    input  logic                   cam_vsync,
    input  logic                   cam_href,
    input  logic [15:0]            cam_data,      // rgb565
    input  logic                   disp_vs,
    input  logic                   disp_de,
    input  logic [`DO_CLASS_N-1:0] class_onehot,  // classifier result
    output logic                   out_de,
    output logic [7:0]             rgb_r,
    output logic [7:0]             rgb_g,
    output logic [7:0]             rgb_b
);

    // --------------------
    // camera side
    bin_wr_if  wr_bus ();
    row_bits_t shown_rows [`DO_IMG_N];            // latched image, one per row
    rgb888_t   rgb;

    cam_sampler u_sampler (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_href  (cam_href),
        .cam_data  (cam_data),
        .wr_bus    (wr_bus.sampler)
    );

    for (genvar r = 0; r < `DO_IMG_N; r++) begin : g_row
        bin_row #(
            .ROW_ID (cell_idx_t'(r))
        ) u_row (
            .video_clk (video_clk),
            .rst_n     (rst_n),
            .wr_bus    (wr_bus.store),
            .shown     (shown_rows[r])
        );
    end

    // --------------------
    // display side
    overlay_mixer u_mixer (
        .video_clk    (video_clk),
        .rst_n        (rst_n),
        .disp_vs      (disp_vs),
        .disp_de      (disp_de),
        .rows         (shown_rows),
        .class_onehot (class_onehot),
        .out_de       (out_de),
        .rgb          (rgb)
    );

    assign rgb_r = rgb[23:16];
    assign rgb_g = rgb[15:8];
    assign rgb_b = rgb[7:0];

endmodule

/* verification/digit_overlay_chk.sv */
`timescale 1ns/1ps

module digit_overlay_chk (
    input logic        video_clk,
    input logic        rst_n,
    input logic        disp_de,
    input logic        out_de,
    input logic        cam_href,
    input logic        wr,           // sampler write strobe
    input logic [23:0] rgb
);

    // --------------------
    // display pipeline
    property de_delay_p;
        @(posedge video_clk) disable iff (!rst_n)
        out_de == $past(disp_de, 2);              // counters plus layer stage
    endproperty

    property rgb_known_p;
        @(posedge video_clk) disable iff (!rst_n)
        !$isunknown(rgb);
    endproperty

    // --------------------
    // camera strobes
    property wr_in_line_p;
        @(posedge video_clk) disable iff (!rst_n)
        wr |-> $past(cam_href);                   // pixel came from an active line
    endproperty

    a_de_delay: assert property (de_delay_p)
        else $error("out_de is not disp_de delayed by 2 cycles");
    a_rgb_known: assert property (rgb_known_p)
        else $error("rgb carries an unknown value after reset");
    a_wr_in_line: assert property (wr_in_line_p)
        else $error("write strobe without an active camera line");

endmodule

bind digit_overlay_top digit_overlay_chk u_chk (
    .video_clk (video_clk),
    .rst_n     (rst_n),
    .disp_de   (disp_de),
    .out_de    (out_de),
    .cam_href  (cam_href),
    .wr        (wr_bus.wr),
    .rgb       ({rgb_r, rgb_g, rgb_b})
);

/* verification/digit_overlay_tb.sv */
`timescale 1ns/1ps
`include "digit_overlay_params.svh"

module digit_overlay_tb
    import digit_overlay_pkg::*;
();

    // --------------------
    // stimulus dimensions
    localparam int CLK_NS     = 100;
    localparam int RST_CYC    = 5;
    localparam int CAM_W      = 232;          // pixels per camera line
    localparam int CAM_H      = 232;          // camera lines
    localparam int CAM_BLANK  = 4;            // href low between lines
    localparam int VS_CYC     = 8;
    localparam int DISP_W     = 1280;
    localparam int DISP_H     = 480;          // full-width lines
    localparam int DISP_EXT_W = 384;          // short lines for the class bar
    localparam int DISP_LINES = 610;          // class bar ends on line 607
    localparam int DISP_BLANK = 4;
    localparam int DRAIN_CYC  = 16;

    localparam int CAM_FRAME_CYC  = CAM_H * (CAM_W + CAM_BLANK);
    localparam int DISP_FRAME_CYC = VS_CYC + DISP_H * (DISP_W + DISP_BLANK)
                                  + (DISP_LINES - DISP_H) * (DISP_EXT_W + DISP_BLANK);
    localparam int TOTAL_CYC      = RST_CYC + 1 + 2 * (CAM_FRAME_CYC + 2 * VS_CYC)
                                  + 4 * DISP_FRAME_CYC + DRAIN_CYC;
    localparam longint WATCHDOG_NS = 2 * longint'(TOTAL_CYC) * CLK_NS;

    typedef logic [`DO_DISP_X_W-1:0]          disp_x_t;
    typedef logic [`DO_DISP_Y_W-1:0]          disp_y_t;
    typedef logic [`DO_IMG_N-1:0][`DO_IMG_N-1:0] image_t;  // [row][col]

    // --------------------
    // DUT signals
    logic                   video_clk = 1'b0;
    logic                   rst_n;
    logic                   cam_vsync;
    logic                   cam_href;
    logic [15:0]            cam_data;
    logic                   disp_vs;
    logic                   disp_de;
    logic [`DO_CLASS_N-1:0] class_onehot;
    logic                   out_de;
    logic [7:0]             rgb_r;
    logic [7:0]             rgb_g;
    logic [7:0]             rgb_b;

    // model state
    image_t  live_img;                        // what the sampler has written
    image_t  shown_img;                       // what the display should show
    logic    cur_de;                          // tb raster in step with disp_de
    disp_x_t cur_x;
    disp_y_t cur_y;
    logic    d1_de;
    logic    d2_de;
    disp_x_t d1_x;
    disp_x_t d2_x;
    disp_y_t d1_y;
    disp_y_t d2_y;
    integer  seed;

    always #(CLK_NS / 2) video_clk = ~video_clk;

    digit_overlay_top UUT (
        .video_clk    (video_clk),
        .rst_n        (rst_n),
        .cam_vsync    (cam_vsync),
        .cam_href     (cam_href),
        .cam_data     (cam_data),
        .disp_vs      (disp_vs),
        .disp_de      (disp_de),
        .class_onehot (class_onehot),
        .out_de       (out_de),
        .rgb_r        (rgb_r),
        .rgb_g        (rgb_g),
        .rgb_b        (rgb_b)
    );

    // --------------------
    // reference model
    function automatic logic dark_bit(input rgb565_t px);
        int sum;
        sum = int'(px[15:11]) + int'(px[10:5]) + int'(px[4:0]);
        return (sum < `DO_BIN_THRESH);
    endfunction

    function automatic rgb888_t expected_rgb(input int x, input int y, input image_t img,
                                             input logic [`DO_CLASS_N-1:0] cls);
        int bx;
        int by;
        int cx;
        int cy;
        bx = x >> `DO_BIN_CELL_SHIFT;
        by = y >> `DO_BIN_CELL_SHIFT;
        cx = x >> `DO_CLASS_CELL_SHIFT;
        cy = y >> `DO_CLASS_CELL_SHIFT;
        if (bx >= `DO_BIN_X0 && bx < `DO_BIN_X0 + `DO_IMG_N
            && by >= `DO_BIN_Y0 && by < `DO_BIN_Y0 + `DO_IMG_N) begin
            return {24{img[by - `DO_BIN_Y0][bx - `DO_BIN_X0]}};   // binary window wins
        end
        if (cx >= `DO_CLASS_X0 && cx < `DO_CLASS_X0 + `DO_CLASS_N && cy == `DO_CLASS_Y0) begin
            return {24{cls[cx - `DO_CLASS_X0]}};
        end
        return {8'(x), 8'(y), 8'hff};                              // gradient
    endfunction

    // dark and bright pixels around the threshold
    function automatic rgb565_t make_pixel(input logic [31:0] r);
        case (r[2:0])
            3'd0:       return {5'd10, 6'd10, 5'd10};               // sum 30 is not dark
            3'd1:       return {5'd10, 6'd10, 5'd9};                // sum 29 is dark
            3'd2, 3'd3: return {1'b0, r[7:4], 2'b00, r[11:8], 1'b0, r[15:12]};
            default:    return r[31:16];                            // mostly bright
        endcase
    endfunction

    function automatic int line_len(input int line);
        return (line < DISP_H) ? DISP_W : DISP_EXT_W;
    endfunction

    task automatic check_val(input string name, input logic [23:0] got, input logic [23:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            $display("TEST FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // --------------------
    // stimulus tasks
    task automatic feed_cam_frame();
        logic [31:0] rnd;
        rgb565_t     px;
        for (int line = 0; line < CAM_H; line++) begin
            for (int pix = 0; pix < CAM_W; pix++) begin
                @(posedge video_clk);
                rnd = $random(seed);
                px  = make_pixel(rnd);
                cam_href <= 1'b1;
                cam_data <= px;
                if (line % 8 == 0 && pix % 8 == 0 && line / 8 < `DO_IMG_N
                    && pix / 8 < `DO_IMG_N) begin
                    live_img[line / 8][pix / 8] = dark_bit(px);
                end
            end
            repeat (CAM_BLANK) begin
                @(posedge video_clk);
                cam_href <= 1'b0;
            end
        end
    endtask

    task automatic pulse_cam_vsync();
        repeat (VS_CYC) begin
            @(posedge video_clk);
            cam_vsync <= 1'b1;
        end
        repeat (VS_CYC) begin
            @(posedge video_clk);
            cam_vsync <= 1'b0;
        end
        shown_img = live_img;                 // swap done well before next line
    endtask

    task automatic scan_disp_frame(input logic [`DO_CLASS_N-1:0] cls);
        repeat (VS_CYC) begin
            @(posedge video_clk);
            class_onehot <= cls;
            disp_vs      <= 1'b1;
            disp_de      <= 1'b0;
            cur_de       <= 1'b0;
        end
        for (int line = 0; line < DISP_LINES; line++) begin
            for (int pix = 0; pix < line_len(line); pix++) begin
                @(posedge video_clk);
                disp_vs <= 1'b0;
                disp_de <= 1'b1;
                cur_de  <= 1'b1;
                cur_x   <= disp_x_t'(pix);
                cur_y   <= disp_y_t'(line);
            end
            repeat (DISP_BLANK) begin
                @(posedge video_clk);
                disp_de <= 1'b0;
                cur_de  <= 1'b0;
            end
        end
    endtask

    // --------------------
    // tb raster delayed by 2 cycles for the compare
    always @(posedge video_clk) begin
        if (!rst_n) begin
            d1_de <= 1'b0;
            d2_de <= 1'b0;
            d1_x  <= '0;
            d2_x  <= '0;
            d1_y  <= '0;
            d2_y  <= '0;
        end else begin
            d1_de <= cur_de;
            d1_x  <= cur_x;
            d1_y  <= cur_y;
            d2_de <= d1_de;
            d2_x  <= d1_x;
            d2_y  <= d1_y;
        end
    end

    always @(posedge video_clk) begin
        if (rst_n) begin
            check_val("out_de", {23'd0, out_de}, {23'd0, d2_de});
            if (out_de) begin
                check_val("rgb", {rgb_r, rgb_g, rgb_b},
                          expected_rgb(int'(d2_x), int'(d2_y), shown_img, class_onehot));
            end
        end
    end

    // --------------------
    // main sequence
    initial begin
        seed         = 32'hc17838be;
        rst_n        = 1'b0;
        cam_vsync    = 1'b0;
        cam_href     = 1'b0;
        cam_data     = '0;
        disp_vs      = 1'b0;
        disp_de      = 1'b0;
        class_onehot = '0;
        cur_de       = 1'b0;
        cur_x        = '0;
        cur_y        = '0;
        live_img     = '0;
        shown_img    = '0;
        repeat (RST_CYC) @(posedge video_clk);
        rst_n <= 1'b1;
        @(posedge video_clk);

        scan_disp_frame(10'b0000000000);      // empty image after reset

        feed_cam_frame();                     // frame a
        pulse_cam_vsync();
        scan_disp_frame(10'b0000001000);      // image a with class 3

        feed_cam_frame();                     // frame b not latched yet
        scan_disp_frame(10'b0010000000);      // still image a with class 7
        pulse_cam_vsync();
        scan_disp_frame(10'b0000000001);      // image b with class 0

        repeat (DRAIN_CYC) @(posedge video_clk);
        $display("TEST PASSED");
        $finish;
    end

    // watchdog at twice the stimulus length
    initial begin
        #(WATCHDOG_NS);
        $display("TEST FAILED");
        $display("run timed out after %0d ns", WATCHDOG_NS);
        $fatal(1, "watchdog expired");
    end

endmodule

/* digit_overlay.f */
+incdir+include
logic/digit_overlay_pkg.sv
logic/bin_wr_if.sv
logic/cam_sampler.sv
logic/bin_row.sv
logic/overlay_mixer.sv
logic/digit_overlay_top.sv
verification/digit_overlay_chk.sv
verification/digit_overlay_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the digit_overlay testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f digit_overlay.f \
    --top-module digit_overlay_tb -o sim_digit_overlay
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_digit_overlay > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
exit 1
